//--- include/tb_host_tasks.svh
// bus master and video driver tasks, textually part of the testbench module
// every bus wait gives up after BUS_TIMEOUT cycles
// video is only driven while the bus is idle

`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

function automatic logic [31:0] ram_addr(input int idx);
  return RAM_BASE | (32'(idx) << 2);
endfunction

// one request, held until ready is seen, then valid drops for a cycle
task automatic bus_transfer(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb);
  bit got_ready;
  got_ready = 1'b0;
  @(posedge clk);
  #1;
  i_bus_valid = 1'b1;
  i_bus_addr  = addr;
  i_bus_wdata = wdata;
  i_bus_wstrb = strb;
  // ready is looked at mid-cycle, away from the clock edge
  for (int n = 0; n < BUS_TIMEOUT && !got_ready; n++) begin
    @(negedge clk);
    got_ready = o_bus_ready;
  end
  if (!got_ready) begin
    stop_with_failure($sformatf("no bus ready for address %h within %0d cycles",
                                addr, BUS_TIMEOUT));
  end
  @(posedge clk);
  #1;
  i_bus_valid = 1'b0;
  i_bus_wstrb = 4'h0;
endtask

task automatic bus_read(input logic [31:0] addr, input logic [31:0] expected);
  exp_rdata = expected;
  rd_check  = 1'b1;
  bus_transfer(addr, 32'h0, 4'h0);
  rd_check  = 1'b0;
endtask

task automatic write_ram_word(input int idx, input logic [31:0] data);
  bus_transfer(ram_addr(idx), data, 4'hF);
  ram_model[idx] = data;
endtask

task automatic start_frame();
  @(posedge clk);
  #1;
  i_vid_vs = 1'b1;
  i_vid_de = 1'b0;
  exp_rgb  = 24'h000000;
endtask

// hsync cycle, n_cols visible pixels, then a short blank tail
task automatic drive_video_line(input int row, input int n_cols, input bit osd_on);
  @(posedge clk);
  #1;
  i_vid_vs = 1'b0;
  i_vid_hs = 1'b1;
  i_vid_de = 1'b0;
  exp_rgb  = 24'h000000;
  for (int col = 0; col < n_cols; col++) begin
    @(posedge clk);
    #1;
    i_vid_hs   = 1'b0;
    i_vid_de   = 1'b1;
    i_core_rgb = 24'($urandom);
    exp_rgb    = expected_pixel(row, col, i_core_rgb, osd_on);
  end
  for (int n = 0; n < 3; n++) begin
    @(posedge clk);
    #1;
    i_vid_de   = 1'b0;
    i_core_rgb = 24'($urandom);
    exp_rgb    = 24'h000000;
  end
endtask

`endif

//--- bench/tb_core_host.sv
// testbench for core_host_top, which plays the cpu bus master and the video source
// video runs only while no bus request is open, so ram ready latency stays fixed
// RAM_WORDS here must match the value handed to the DUT

`timescale 1ns/1ps
`default_nettype none

module tb_core_host;

  localparam int          RAM_WORDS   = 1024;
  localparam int          BUS_TIMEOUT = 20;
  localparam logic [31:0] RAM_BASE    = 32'h1000_0000;
  localparam logic [31:0] REGS_BASE   = 32'h3000_0000;
  localparam logic [23:0] FG_RGB      = 24'hFFFFFF;
  localparam logic [23:0] BG_RGB      = 24'h304050;

  logic        clk;
  logic        rst;
  logic        i_bus_valid;
  logic [31:0] i_bus_addr;
  logic [31:0] i_bus_wdata;
  logic [3:0]  i_bus_wstrb;
  logic        o_bus_ready;
  logic [31:0] o_bus_rdata;
  logic        i_vid_de;
  logic        i_vid_hs;
  logic        i_vid_vs;
  logic [23:0] i_core_rgb;
  logic [23:0] o_vid_rgb;
  logic [15:0] i_cont1_key;
  logic [15:0] i_cont2_key;
  logic [31:0] o_load_addr;
  logic [7:0]  o_load_data;
  logic [5:0]  o_load_we;
  logic        o_emu_rst;
  logic [1:0]  o_emu_cart_type;
  logic [4:0]  o_joy1;
  logic [4:0]  o_joy2;
  logic [63:0] o_keyboard_mask;

  // reference state and expectations
  logic [31:0] ram_model [RAM_WORDS];
  logic [6:0]  emu_model;
  logic [63:0] kbd_model;
  logic [31:0] exp_rdata;
  logic [5:0]  exp_load_we;
  logic [31:0] exp_load_addr;
  logic [7:0]  exp_load_data;
  logic [23:0] exp_rgb;
  logic        exp_emu_rst;
  logic [1:0]  exp_cart_type;
  logic [4:0]  exp_joy1;
  logic [4:0]  exp_joy2;
  logic        idle_check;
  logic        out_check;
  logic        rd_check;
  logic        load_check;

  always #50 clk = ~clk;

  core_host_top #(.RAM_WORDS(RAM_WORDS)) core_host_top_i (
    .clk (clk), .rst (rst),
    .i_bus_valid (i_bus_valid), .i_bus_addr (i_bus_addr),
    .i_bus_wdata (i_bus_wdata), .i_bus_wstrb (i_bus_wstrb),
    .o_bus_ready (o_bus_ready), .o_bus_rdata (o_bus_rdata),
    .i_vid_de (i_vid_de), .i_vid_hs (i_vid_hs), .i_vid_vs (i_vid_vs),
    .i_core_rgb (i_core_rgb), .o_vid_rgb (o_vid_rgb),
    .i_cont1_key (i_cont1_key), .i_cont2_key (i_cont2_key),
    .o_load_addr (o_load_addr), .o_load_data (o_load_data), .o_load_we (o_load_we),
    .o_emu_rst (o_emu_rst), .o_emu_cart_type (o_emu_cart_type),
    .o_joy1 (o_joy1), .o_joy2 (o_joy2), .o_keyboard_mask (o_keyboard_mask)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic string mismatch_line(input string name, input logic [63:0] exp,
                                          input logic [63:0] got);
    return $sformatf("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
  endfunction

  // select 1 routes controller 1, select 2 routes controller 2
  function automatic logic [4:0] joy_expect(input logic [1:0] sel, input logic [15:0] key1,
                                            input logic [15:0] key2);
    if (sel == 2'd1) return key1[4:0];
    if (sel == 2'd2) return key2[4:0];
    return 5'd0;
  endfunction

  // pixel at column col shows the osd bit of column col-1
  function automatic logic [23:0] expected_pixel(input int row, input int col,
                                                 input logic [23:0] core, input bit osd_on);
    int          bit_col;
    int          byte_idx;
    logic [31:0] word;
    logic [7:0]  glyph;
    if (!osd_on || col >= 256 || row >= 64) return core;
    if (col == 0) return BG_RGB;
    bit_col  = col - 1;
    byte_idx = row * 32 + bit_col / 8;
    word     = ram_model[byte_idx / 4];
    glyph    = word[(byte_idx % 4) * 8 +: 8];
    return glyph[7 - bit_col % 8] ? FG_RGB : BG_RGB;
  endfunction

  always_comb begin
    exp_emu_rst   = ~emu_model[0];
    exp_cart_type = emu_model[6:5];
    exp_joy1      = joy_expect(emu_model[2:1], i_cont1_key, i_cont2_key);
    exp_joy2      = joy_expect(emu_model[4:3], i_cont1_key, i_cont2_key);
  end

  `include "tb_host_tasks.svh"

  ////////////////////
  // checks

  a_idle_ready: assert property (@(posedge clk) disable iff (rst)
    idle_check |-> !o_bus_ready)
    else stop_with_failure(mismatch_line("o_bus_ready", 64'(0), 64'($sampled(o_bus_ready))));
  a_load_quiet: assert property (@(posedge clk) disable iff (rst)
    !i_bus_valid |-> o_load_we == '0)
    else stop_with_failure(mismatch_line("o_load_we", 64'(0), 64'($sampled(o_load_we))));
  a_latency: assert property (@(posedge clk) disable iff (rst)
    (i_bus_valid && !o_bus_ready) |=> o_bus_ready)
    else stop_with_failure(mismatch_line("o_bus_ready", 64'(1), 64'($sampled(o_bus_ready))));
  a_rdata: assert property (@(posedge clk) disable iff (rst)
    (rd_check && o_bus_ready) |-> o_bus_rdata == exp_rdata)
    else stop_with_failure(mismatch_line("o_bus_rdata", 64'($sampled(exp_rdata)),
                                         64'($sampled(o_bus_rdata))));
  a_load_we: assert property (@(posedge clk) disable iff (rst)
    (load_check && o_bus_ready) |-> o_load_we == exp_load_we)
    else stop_with_failure(mismatch_line("o_load_we", 64'($sampled(exp_load_we)),
                                         64'($sampled(o_load_we))));
  a_load_addr: assert property (@(posedge clk) disable iff (rst)
    (load_check && o_bus_ready && exp_load_we != '0) |-> o_load_addr == exp_load_addr)
    else stop_with_failure(mismatch_line("o_load_addr", 64'($sampled(exp_load_addr)),
                                         64'($sampled(o_load_addr))));
  a_load_data: assert property (@(posedge clk) disable iff (rst)
    (load_check && o_bus_ready && exp_load_we != '0) |-> o_load_data == exp_load_data)
    else stop_with_failure(mismatch_line("o_load_data", 64'($sampled(exp_load_data)),
                                         64'($sampled(o_load_data))));
  a_emu_rst: assert property (@(posedge clk) disable iff (rst)
    out_check |-> o_emu_rst == exp_emu_rst)
    else stop_with_failure(mismatch_line("o_emu_rst", 64'($sampled(exp_emu_rst)),
                                         64'($sampled(o_emu_rst))));
  a_cart_type: assert property (@(posedge clk) disable iff (rst)
    out_check |-> o_emu_cart_type == exp_cart_type)
    else stop_with_failure(mismatch_line("o_emu_cart_type", 64'($sampled(exp_cart_type)),
                                         64'($sampled(o_emu_cart_type))));
  a_joy1: assert property (@(posedge clk) disable iff (rst)
    out_check |-> o_joy1 == exp_joy1)
    else stop_with_failure(mismatch_line("o_joy1", 64'($sampled(exp_joy1)),
                                         64'($sampled(o_joy1))));
  a_joy2: assert property (@(posedge clk) disable iff (rst)
    out_check |-> o_joy2 == exp_joy2)
    else stop_with_failure(mismatch_line("o_joy2", 64'($sampled(exp_joy2)),
                                         64'($sampled(o_joy2))));
  a_kbd: assert property (@(posedge clk) disable iff (rst)
    out_check |-> o_keyboard_mask == kbd_model)
    else stop_with_failure(mismatch_line("o_keyboard_mask", $sampled(kbd_model),
                                         $sampled(o_keyboard_mask)));
  a_vid: assert property (@(posedge clk) disable iff (rst)
    o_vid_rgb == exp_rgb)
    else stop_with_failure(mismatch_line("o_vid_rgb", 64'($sampled(exp_rgb)),
                                         64'($sampled(o_vid_rgb))));

  ////////////////////
  // sequence

  initial begin
    int          idx;
    int          lane;
    logic [31:0] word;
    logic [31:0] addr;
    logic [6:0]  ctrl;
    void'($urandom(32'hbfdb));
    clk = 1'b0;
    rst = 1'b1;
    i_bus_valid = 1'b0;
    i_bus_addr  = 32'h0;
    i_bus_wdata = 32'h0;
    i_bus_wstrb = 4'h0;
    i_vid_de    = 1'b0;
    i_vid_hs    = 1'b0;
    i_vid_vs    = 1'b0;
    i_core_rgb  = 24'h0;
    i_cont1_key = 16'h0;
    i_cont2_key = 16'h0;
    emu_model   = '0;
    kbd_model   = '0;
    exp_rdata   = '0;
    exp_load_we = '0;
    exp_load_addr = '0;
    exp_load_data = '0;
    exp_rgb     = '0;
    idle_check  = 1'b0;
    out_check   = 1'b0;
    rd_check    = 1'b0;
    load_check  = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // quiet bus and machine held in reset
    idle_check = 1'b1;
    out_check  = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    idle_check = 1'b0;

    // shared ram write and read back
    for (int n = 0; n < 4; n++) begin
      idx  = $urandom_range(RAM_WORDS - 1, 0);
      word = $urandom;
      write_ram_word(idx, word);
      bus_read(ram_addr(idx), ram_model[idx]);
    end

    // emulator control and joystick routing, every select on both ports
    for (int sel = 0; sel < 4; sel++) begin
      ctrl = {2'($urandom), 2'((sel + 2) % 4), 2'(sel), 1'(sel)};
      out_check = 1'b0;
      bus_transfer(REGS_BASE | 32'hC, {25'($urandom), ctrl}, 4'hF);
      emu_model = ctrl;
      out_check = 1'b1;
      bus_read(REGS_BASE | 32'hC, {25'd0, ctrl});
      for (int n = 0; n < 6; n++) begin
        @(posedge clk);
        #1;
        i_cont1_key = 16'($urandom);
        i_cont2_key = 16'($urandom);
      end
    end
    out_check = 1'b0;
    word = $urandom;
    addr = $urandom;
    bus_transfer(REGS_BASE | 32'h4, word, 4'hF);
    bus_transfer(REGS_BASE | 32'h8, addr, 4'hF);
    kbd_model = {addr, word};
    out_check = 1'b1;

    // loader pages in target order, cartridge last
    for (int t = 0; t < 6; t++) begin
      addr = (t < 5) ? {16'h5000 + 16'(t), 16'($urandom)} : {8'h51, 24'($urandom)};
      addr[1:0] = 2'b00;
      lane = $urandom_range(3, 0);
      word = $urandom;
      exp_load_we   = 6'(1 << t);
      exp_load_addr = addr + 32'(lane);
      exp_load_data = word[lane*8 +: 8];
      load_check = 1'b1;
      bus_transfer(addr, word, 4'(1 << lane));
      load_check = 1'b0;
    end
    exp_load_we = '0;
    load_check  = 1'b1;
    bus_transfer({16'h5000, 16'($urandom & 32'hFFFC)}, $urandom, 4'b0011);
    load_check  = 1'b0;

    // osd on, row 0 all set, row 1 all clear
    for (int w = 0; w < 16; w++) begin
      write_ram_word(w, (w < 8) ? 32'hFFFF_FFFF : 32'h0);
    end
    bus_transfer(REGS_BASE, 32'h1, 4'hF);
    start_frame();
    drive_video_line(0, 300, 1'b1);
    drive_video_line(1, 300, 1'b1);

    // osd off passes the core video
    bus_transfer(REGS_BASE, 32'h0, 4'hF);
    start_frame();
    for (int row = 0; row < 3; row++) begin
      drive_video_line(row, 300, 1'b0);
    end

    repeat (2) @(posedge clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/core_host_top.sv
// host side of the core, driven by an external cpu bus master
// the machine itself sits outside and takes the load, control and joystick outputs
// one clock for bus and video

`timescale 1ns/1ps
`default_nettype none

module core_host_top #(
  parameter int RAM_WORDS = 1024
) (
  input  logic                              clk,
  input  logic                              rst,
  // cpu bus
  input  logic                              i_bus_valid,
  input  logic [host_pkg::BUS_W-1:0]        i_bus_addr,
  input  logic [host_pkg::BUS_W-1:0]        i_bus_wdata,
  input  logic [host_pkg::STRB_W-1:0]       i_bus_wstrb,
  output logic                              o_bus_ready,
  output logic [host_pkg::BUS_W-1:0]        o_bus_rdata,
  // core video in, overlaid video out
  input  logic                              i_vid_de,
  input  logic                              i_vid_hs,
  input  logic                              i_vid_vs,
  input  logic [23:0]                       i_core_rgb,
  output logic [23:0]                       o_vid_rgb,
  // controllers
  input  logic [host_pkg::KEY_W-1:0]        i_cont1_key,
  input  logic [host_pkg::KEY_W-1:0]        i_cont2_key,
  // machine side
  output logic [host_pkg::BUS_W-1:0]        o_load_addr,
  output logic [7:0]                        o_load_data,
  output logic [host_pkg::LOAD_TARGETS-1:0] o_load_we,
  output logic                              o_emu_rst,
  output logic [1:0]                        o_emu_cart_type,
  output logic [host_pkg::JOY_W-1:0]        o_joy1,
  output logic [host_pkg::JOY_W-1:0]        o_joy2,
  output logic [63:0]                       o_keyboard_mask
);

  import host_pkg::*;

  logic                   ram_sel;
  logic                   reg_wr;
  logic                   load_sel;
  logic [BUS_W-1:0]       ram_rdata;
  logic [BUS_W-1:0]       reg_rdata;
  logic [OSD_CTRL_W-1:0]  osd_ctrl;
  logic                   osd_fetch;
  logic [OSD_WORD_AW-1:0] osd_word_addr;

  host_bus_decode #(.RAM_WORDS(RAM_WORDS)) u_decode (
    .clk         (clk),
    .rst         (rst),
    .i_bus_valid (i_bus_valid),
    .i_bus_addr  (i_bus_addr),
    .i_bus_wstrb (i_bus_wstrb),
    .i_ram_rdata (ram_rdata),
    .i_reg_rdata (reg_rdata),
    .i_osd_busy  (osd_fetch),
    .o_bus_ready (o_bus_ready),
    .o_bus_rdata (o_bus_rdata),
    .o_ram_sel   (ram_sel),
    .o_reg_wr    (reg_wr),
    .o_load_sel  (load_sel)
  );

  host_ctrl_regs u_regs (
    .clk             (clk),
    .rst             (rst),
    .i_reg_wr        (reg_wr),
    .i_bus_addr      (i_bus_addr),
    .i_bus_wdata     (i_bus_wdata),
    .i_cont1_key     (i_cont1_key),
    .i_cont2_key     (i_cont2_key),
    .o_reg_rdata     (reg_rdata),
    .o_osd_ctrl      (osd_ctrl),
    .o_keyboard_mask (o_keyboard_mask),
    .o_emu_rst       (o_emu_rst),
    .o_joy1          (o_joy1),
    .o_joy2          (o_joy2),
    .o_cart_type     (o_emu_cart_type)
  );

  osd_shared_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
    .clk             (clk),
    .i_ram_sel       (ram_sel),
    .i_bus_addr      (i_bus_addr),
    .i_bus_wdata     (i_bus_wdata),
    .i_bus_wstrb     (i_bus_wstrb),
    .i_osd_fetch     (osd_fetch),
    .i_osd_word_addr (osd_word_addr),
    .o_ram_rdata     (ram_rdata)
  );

  osd_overlay u_osd (
    .clk             (clk),
    .rst             (rst),
    .i_vid_de        (i_vid_de),
    .i_vid_hs        (i_vid_hs),
    .i_vid_vs        (i_vid_vs),
    .i_core_rgb      (i_core_rgb),
    .i_osd_ctrl      (osd_ctrl),
    .i_ram_rdata     (ram_rdata),
    .o_osd_fetch     (osd_fetch),
    .o_osd_word_addr (osd_word_addr),
    .o_vid_rgb       (o_vid_rgb)
  );

  loader_write_unpack u_loader (
    .i_load_sel  (load_sel),
    .i_bus_valid (i_bus_valid),
    .i_bus_addr  (i_bus_addr),
    .i_bus_wdata (i_bus_wdata),
    .i_bus_wstrb (i_bus_wstrb),
    .o_load_addr (o_load_addr),
    .o_load_data (o_load_data),
    .o_load_we   (o_load_we)
  );

endmodule

`default_nettype wire

//--- rtl/host_bus_decode.sv
// cpu bus decoder with a registered one-cycle ready
// unmapped regions, and ram words beyond RAM_WORDS, never get ready
// ram accesses wait out any cycle with an osd fetch

`timescale 1ns/1ps
`default_nettype none

module host_bus_decode #(
  parameter int RAM_WORDS = 1024
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_bus_valid,
  input  logic [host_pkg::BUS_W-1:0]  i_bus_addr,
  input  logic [host_pkg::STRB_W-1:0] i_bus_wstrb,
  input  logic [host_pkg::BUS_W-1:0]  i_ram_rdata,
  input  logic [host_pkg::BUS_W-1:0]  i_reg_rdata,
  input  logic                        i_osd_busy,
  output logic                        o_bus_ready,
  output logic [host_pkg::BUS_W-1:0]  o_bus_rdata,
  output logic                        o_ram_sel,
  output logic                        o_reg_wr,
  output logic                        o_load_sel
);

  import host_pkg::*;

  host_addr_u addr_u;
  logic       ram_hit;
  logic       ready_d;
  logic       ready_q;

  assign addr_u = i_bus_addr;

  // word index must land inside the shared ram
  assign ram_hit = (addr_u.rgn.region == REGION_RAM) &&
                   (addr_u.rgn.offset[27:2] < 26'(RAM_WORDS));

  assign o_ram_sel  = i_bus_valid && ram_hit;
  assign o_reg_wr   = i_bus_valid && (addr_u.rgn.region == REGION_REGS) &&
                      (i_bus_wstrb == {STRB_W{1'b1}});
  assign o_load_sel = (addr_u.rgn.region == REGION_LOAD) && (|i_bus_wstrb);

  ////////////////////
  // ready

  always_comb begin
    case (addr_u.rgn.region)
      REGION_RAM:  ready_d = ram_hit && !i_osd_busy && !ready_q && i_bus_valid;
      REGION_REGS: ready_d = !ready_q && i_bus_valid;
      REGION_LOAD: ready_d = !ready_q && i_bus_valid;
      default:     ready_d = 1'b0;
    endcase
  end

  // drops again after one cycle so the master can release valid
  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= ready_d;
    end
  end

  assign o_bus_ready = ready_q;

  ////////////////////
  // read data

  always_comb begin
    case (addr_u.rgn.region)
      REGION_RAM:  o_bus_rdata = i_ram_rdata;
      REGION_REGS: o_bus_rdata = i_reg_rdata;
      default:     o_bus_rdata = '0;
    endcase
  end

  // the master must still hold its request when we acknowledge it
  a_ready_with_valid: assert property (
    @(posedge clk) disable iff (rst) o_bus_ready |-> i_bus_valid
  ) else $error("bus ready without valid");

endmodule

`default_nettype wire

//--- rtl/host_ctrl_regs.sv
// osd control, keyboard mask and emulator control registers
// only full-word writes land; byte writes are ignored
// only the emulator control word reads back

`timescale 1ns/1ps
`default_nettype none

module host_ctrl_regs (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            i_reg_wr,
  input  logic [host_pkg::BUS_W-1:0]      i_bus_addr,
  input  logic [host_pkg::BUS_W-1:0]      i_bus_wdata,
  input  logic [host_pkg::KEY_W-1:0]      i_cont1_key,
  input  logic [host_pkg::KEY_W-1:0]      i_cont2_key,
  output logic [host_pkg::BUS_W-1:0]      o_reg_rdata,
  output logic [host_pkg::OSD_CTRL_W-1:0] o_osd_ctrl,
  output logic [63:0]                     o_keyboard_mask,
  output logic                            o_emu_rst,
  output logic [host_pkg::JOY_W-1:0]      o_joy1,
  output logic [host_pkg::JOY_W-1:0]      o_joy2,
  output logic [1:0]                      o_cart_type
);

  import host_pkg::*;

  logic [OSD_CTRL_W-1:0] osd_ctrl_q;
  logic [63:0]           kbd_mask_q;
  logic [EMU_CTRL_W-1:0] emu_ctrl_q;
  logic [27:0]           reg_offset;

  // select 1 is controller 1, select 2 is controller 2
  function automatic logic [JOY_W-1:0] joy_route(
    input logic [1:0]       sel,
    input logic [KEY_W-1:0] key1,
    input logic [KEY_W-1:0] key2
  );
    case (sel)
      2'd1:    return key1[JOY_W-1:0];
      2'd2:    return key2[JOY_W-1:0];
      default: return '0;
    endcase
  endfunction

  assign reg_offset = i_bus_addr[27:0];

  ////////////////////
  // register writes

  always_ff @(posedge clk) begin
    if (rst) begin
      osd_ctrl_q <= '0;
      kbd_mask_q <= '0;
      emu_ctrl_q <= '0;
    end else if (i_reg_wr) begin
      case (reg_offset)
        REG_OSD_CTRL: osd_ctrl_q         <= i_bus_wdata[OSD_CTRL_W-1:0];
        REG_KBD_LO:   kbd_mask_q[31:0]   <= i_bus_wdata;
        REG_KBD_HI:   kbd_mask_q[63:32]  <= i_bus_wdata;
        REG_EMU_CTRL: emu_ctrl_q         <= i_bus_wdata[EMU_CTRL_W-1:0];
        default: ;
      endcase
    end
  end

  assign o_reg_rdata = (reg_offset == REG_EMU_CTRL) ? BUS_W'(emu_ctrl_q) : '0;

  ////////////////////
  // machine outputs

  assign o_osd_ctrl      = osd_ctrl_q;
  assign o_keyboard_mask = kbd_mask_q;

  // machine held in reset until the run bit is set
  assign o_emu_rst   = ~emu_ctrl_q[0];
  assign o_cart_type = emu_ctrl_q[6:5];

  assign o_joy1 = joy_route(emu_ctrl_q[2:1], i_cont1_key, i_cont2_key);
  assign o_joy2 = joy_route(emu_ctrl_q[4:3], i_cont1_key, i_cont2_key);

endmodule

`default_nettype wire

//--- rtl/host_pkg.sv
// shared constants for the host side of the core
// region codes come from address bits 31..28
// the osd window is fixed at 256 x 64 pixels, one bit per pixel

`default_nettype none

package host_pkg;

  // bus geometry
  localparam int BUS_W  = 32;
  localparam int STRB_W = 4;

  ////////////////////
  // region map

  localparam logic [3:0] REGION_RAM  = 4'h1;
  localparam logic [3:0] REGION_REGS = 4'h3;
  localparam logic [3:0] REGION_LOAD = 4'h5;

  // byte offsets inside the register region
  localparam logic [27:0] REG_OSD_CTRL = 28'h000_0000;
  localparam logic [27:0] REG_KBD_LO   = 28'h000_0004;
  localparam logic [27:0] REG_KBD_HI   = 28'h000_0008;
  localparam logic [27:0] REG_EMU_CTRL = 28'h000_000C;

  // loader pages, upper 16 address bits
  localparam logic [15:0] LOAD_PAGE_RAM        = 16'h5000;
  localparam logic [15:0] LOAD_PAGE_BASIC_ROM  = 16'h5001;
  localparam logic [15:0] LOAD_PAGE_CHAR_ROM   = 16'h5002;
  localparam logic [15:0] LOAD_PAGE_KERNAL_ROM = 16'h5003;
  localparam logic [15:0] LOAD_PAGE_DRIVE_ROM  = 16'h5004;
  // cartridge image spans a whole 16 MB block
  localparam logic [7:0]  LOAD_CART_PREFIX     = 8'h51;
  localparam int          LOAD_TARGETS         = 6;

  ////////////////////
  // machine control

  // run, joy1 sel, joy2 sel, cart type
  localparam int EMU_CTRL_W = 7;
  localparam int JOY_W      = 5;
  localparam int KEY_W      = 16;

  ////////////////////
  // osd

  localparam int          OSD_CTRL_W  = 2;
  localparam int          OSD_COLS    = 256;
  localparam int          OSD_ROWS    = 64;
  localparam int          OSD_WORD_AW = $clog2(OSD_COLS / 8 * OSD_ROWS / 4);
  localparam logic [23:0] OSD_FG_RGB  = 24'hFFFFFF;
  localparam logic [23:0] OSD_BG_RGB  = 24'h304050;

  // one bus address seen as region/offset or as page/low half
  typedef union packed {
    struct packed {
      logic [3:0]  region;
      logic [27:0] offset;
    } rgn;
    struct packed {
      logic [15:0] page;
      logic [15:0] low;
    } pg;
  } host_addr_u;

endpackage

`default_nettype wire

//--- rtl/loader_write_unpack.sv
// byte loader for rom and ram images
// only single-strobe writes reach a target
// outputs are combinational and follow the bus while valid is held

`timescale 1ns/1ps
`default_nettype none

module loader_write_unpack (
  input  logic                              i_load_sel,
  input  logic                              i_bus_valid,
  input  logic [host_pkg::BUS_W-1:0]        i_bus_addr,
  input  logic [host_pkg::BUS_W-1:0]        i_bus_wdata,
  input  logic [host_pkg::STRB_W-1:0]       i_bus_wstrb,
  output logic [host_pkg::BUS_W-1:0]        o_load_addr,
  output logic [7:0]                        o_load_data,
  output logic [host_pkg::LOAD_TARGETS-1:0] o_load_we
);

  import host_pkg::*;

  host_addr_u              addr_u;
  logic                    single;
  logic [LOAD_TARGETS-1:0] target;

  assign addr_u = i_bus_addr;

  always_comb begin
    single      = 1'b1;
    o_load_addr = '0;
    o_load_data = '0;
    target      = '0;

    // byte address is the word address plus the lane
    case (i_bus_wstrb)
      4'b0001: begin
        o_load_addr = {i_bus_addr[31:2], 2'd0};
        o_load_data = i_bus_wdata[7:0];
      end
      4'b0010: begin
        o_load_addr = {i_bus_addr[31:2], 2'd1};
        o_load_data = i_bus_wdata[15:8];
      end
      4'b0100: begin
        o_load_addr = {i_bus_addr[31:2], 2'd2};
        o_load_data = i_bus_wdata[23:16];
      end
      4'b1000: begin
        o_load_addr = {i_bus_addr[31:2], 2'd3};
        o_load_data = i_bus_wdata[31:24];
      end
      default: single = 1'b0;
    endcase

    case (addr_u.pg.page)
      LOAD_PAGE_RAM:        target[0] = 1'b1;
      LOAD_PAGE_BASIC_ROM:  target[1] = 1'b1;
      LOAD_PAGE_CHAR_ROM:   target[2] = 1'b1;
      LOAD_PAGE_KERNAL_ROM: target[3] = 1'b1;
      LOAD_PAGE_DRIVE_ROM:  target[4] = 1'b1;
      default: ;
    endcase
    // cartridge last
    if (addr_u.pg.page[15:8] == LOAD_CART_PREFIX) begin
      target[5] = 1'b1;
    end

    o_load_we = (i_load_sel && i_bus_valid && single) ? target : '0;

    // two memories must never take the same byte
    a_load_we_onehot: assert ($onehot0(o_load_we))
      else $error("loader enable not one-hot: %b", o_load_we);
  end

endmodule

`default_nettype wire

//--- rtl/osd_overlay.sv
// one-bit-per-pixel osd window over the core video
// window is x < 256 and y < 64, or y < 8 in short mode
// each pixel shows the bit for the column before it

`timescale 1ns/1ps
`default_nettype none

module osd_overlay (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             i_vid_de,
  input  logic                             i_vid_hs,
  input  logic                             i_vid_vs,
  input  logic [23:0]                      i_core_rgb,
  input  logic [host_pkg::OSD_CTRL_W-1:0]  i_osd_ctrl,
  input  logic [host_pkg::BUS_W-1:0]       i_ram_rdata,
  output logic                             o_osd_fetch,
  output logic [host_pkg::OSD_WORD_AW-1:0] o_osd_word_addr,
  output logic [23:0]                      o_vid_rgb
);

  import host_pkg::*;

  logic [8:0]  x_q;
  logic [8:0]  y_q;
  logic        y_in;
  logic        in_window;
  logic [10:0] byte_addr;
  logic        fetch_q;
  logic [1:0]  lane_q;
  logic [7:0]  lane_byte;
  logic [7:0]  shift_q;
  logic        pix;

  ////////////////////
  // beam position

  always_ff @(posedge clk) begin
    if (rst || i_vid_vs) begin
      x_q <= '0;
      y_q <= '0;
    end else if (i_vid_hs) begin
      x_q <= '0;
      // count a line only if it had visible pixels
      if (x_q != '0) begin
        y_q <= y_q + 9'd1;
      end
    end else if (i_vid_de && x_q != '1) begin
      x_q <= x_q + 9'd1;
    end
  end

  // short mode keeps one text row
  assign y_in      = i_osd_ctrl[1] ? (y_q < 9'd8) : (y_q < 9'(OSD_ROWS));
  assign in_window = i_osd_ctrl[0] && i_vid_de && (x_q < 9'(OSD_COLS)) && y_in;

  ////////////////////
  // glyph fetch

  // row * 32 + x / 8
  assign byte_addr       = {y_q[5:0], x_q[7:3]};
  assign o_osd_word_addr = byte_addr[10:2];
  assign o_osd_fetch     = in_window && (x_q[2:0] == 3'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_q <= 1'b0;
      lane_q  <= '0;
    end else begin
      fetch_q <= o_osd_fetch;
      lane_q  <= byte_addr[1:0];
    end
  end

  // lane 0 sits in bits 7..0
  assign lane_byte = i_ram_rdata[{lane_q, 3'b000} +: 8];

  ////////////////////
  // pixel shifter

  // msb goes out straight from the ram, the rest through the shifter
  always_ff @(posedge clk) begin
    if (rst || i_vid_hs) begin
      shift_q <= '0;
    end else if (fetch_q) begin
      shift_q <= {lane_byte[6:0], 1'b0};
    end else begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  assign pix = fetch_q ? lane_byte[7] : shift_q[7];

  always_comb begin
    if (!i_vid_de) begin
      o_vid_rgb = '0;
    end else if (in_window) begin
      o_vid_rgb = pix ? OSD_FG_RGB : OSD_BG_RGB;
    end else begin
      o_vid_rgb = i_core_rgb;
    end
  end

endmodule

`default_nettype wire

//--- rtl/osd_shared_ram.sv
// byte-laned word ram with one read/write port
// an osd fetch owns the port and drops any cpu write in that cycle
// read data appears one cycle after the address

`timescale 1ns/1ps
`default_nettype none

module osd_shared_ram #(
  parameter int RAM_WORDS = 1024
) (
  input  logic                             clk,
  input  logic                             i_ram_sel,
  input  logic [host_pkg::BUS_W-1:0]       i_bus_addr,
  input  logic [host_pkg::BUS_W-1:0]       i_bus_wdata,
  input  logic [host_pkg::STRB_W-1:0]      i_bus_wstrb,
  input  logic                             i_osd_fetch,
  input  logic [host_pkg::OSD_WORD_AW-1:0] i_osd_word_addr,
  output logic [host_pkg::BUS_W-1:0]       o_ram_rdata
);

  import host_pkg::*;

  localparam int AW = $clog2(RAM_WORDS);

  logic [STRB_W-1:0][7:0] mem [RAM_WORDS];
  logic [AW-1:0]          addr;
  logic                   cpu_wr;

  // osd side has priority
  assign addr   = i_osd_fetch ? AW'(i_osd_word_addr) : i_bus_addr[AW+1:2];
  assign cpu_wr = i_ram_sel && !i_osd_fetch;

  always_ff @(posedge clk) begin
    if (i_osd_fetch || i_ram_sel) begin
      o_ram_rdata <= mem[addr];
    end
    for (int lane = 0; lane < STRB_W; lane++) begin
      if (cpu_wr && i_bus_wstrb[lane]) begin
        mem[addr][lane] <= i_bus_wdata[lane*8 +: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_core_host -f sources.f

# the simulator exits nonzero on a fatal check, the log decides the result
./obj_dir/Vtb_core_host > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi

//--- sources.f
+incdir+include
rtl/host_pkg.sv
rtl/host_bus_decode.sv
rtl/host_ctrl_regs.sv
rtl/osd_shared_ram.sv
rtl/osd_overlay.sv
rtl/loader_write_unpack.sv
rtl/core_host_top.sv
bench/tb_core_host.sv
